// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= hm_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard source/*.sv source/*.svh verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+source
source/hm_trn_pkg.sv
source/hm_apb_pkg.sv
source/hm_rx.sv
source/hm_dw_bank.sv
source/hm_apb_regs.sv
source/hm_top.sv
verif/hm_tb.sv

// ==== source/hm_apb_pkg.sv ====
`include "hm_defines.svh"

package hm_apb_pkg;

  import hm_trn_pkg::*;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`HM_APB_AW-1:0] paddr;
    logic [`HM_DW_W-1:0]   pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`HM_DW_W-1:0] prdata;
    logic                pready;
    logic                pslverr;
  } apb_rsp_t;

  // Receiver status as seen from the host side
  typedef struct packed {
    logic                read_done;
    rx_state_e           state;
    logic [`HM_DW_W-1:0] tlp_count;
  } rx_status_t;

endpackage

// ==== source/hm_apb_regs.sv ====
`timescale 1ns/1ps
`include "hm_defines.svh"

module hm_apb_regs
  import hm_trn_pkg::*;
  import hm_apb_pkg::*;
(
  input  logic                   trn_clk,
  input  logic                   rst_n,
  input  apb_req_t               req,
  input  rx_status_t             status,
  input  logic [`HM_DW_W-1:0]    rd_data_l,
  input  logic [`HM_DW_W-1:0]    rd_data_h,
  output apb_rsp_t               rsp,
  output logic                   dbg_mode,
  output logic [`HM_BANK_AW-1:0] bank_rd_addr
);

  logic                  done;
  logic                  bank_wait;
  logic                  acc;
  logic                  is_ctrl;
  logic                  is_status;
  logic                  is_count;
  logic                  in_win;
  logic                  bank_sel;
  logic                  bank_rd;
  logic                  bad;
  logic [`HM_APB_AW-1:0] win_off;
  logic [`HM_DW_W-1:0]   rdata;

  assign acc       = req.psel && req.penable;
  assign is_ctrl   = (req.paddr == `HM_REG_CTRL);
  assign is_status = (req.paddr == `HM_REG_STATUS);
  assign is_count  = (req.paddr == `HM_REG_COUNT);

  assign win_off  = req.paddr - `HM_BANK_BASE;
  assign in_win   = (req.paddr >= `HM_BANK_BASE) && !win_off[`HM_APB_AW-1];
  assign bank_sel = win_off[`HM_BANK_AW+2];
  assign bank_rd  = in_win && !req.pwrite;

  // Index goes to both banks and the select bit picks the result
  assign bank_rd_addr = win_off[`HM_BANK_AW+1:2];

  // Bank writes are not allowed from the host
  assign bad = (in_win && req.pwrite) || !(in_win || is_ctrl || is_status || is_count);

  always_comb begin
    rdata = '0;
    if (is_ctrl) begin
      rdata[0] = dbg_mode;
    end else if (is_status) begin
      rdata[3:0] = {status.state, done};
    end else if (is_count) begin
      rdata = status.tlp_count;
    end else if (bank_rd) begin
      rdata = bank_sel ? rd_data_h : rd_data_l;
    end
  end

  assign rsp.prdata  = rdata;
  assign rsp.pready  = acc && (!bank_rd || bank_wait);
  assign rsp.pslverr = acc && bad;

  always_ff @(posedge trn_clk) begin
    if (!rst_n) begin
      dbg_mode  <= 1'b0;
      done      <= 1'b0;
      bank_wait <= 1'b0;
    end else begin
      // One wait state while the bank read is in flight
      bank_wait <= acc && bank_rd && !bank_wait;

      if (acc && req.pwrite && is_ctrl) begin
        dbg_mode <= req.pwdata[0];
      end

      // A new completion wins over a clear in the same cycle
      if (status.read_done) begin
        done <= 1'b1;
      end else if (acc && req.pwrite && is_status && req.pwdata[0]) begin
        done <= 1'b0;
      end
    end
  end

  a_penable_after_psel: assert property (@(posedge trn_clk) disable iff (!rst_n)
    req.penable |-> $past(req.psel));

  // An access phase follows a setup phase or a waited access cycle
  a_pready_in_access: assert property (@(posedge trn_clk) disable iff (!rst_n)
    rsp.pready |-> $past(req.psel && !(req.penable && rsp.pready)));

endmodule

// ==== source/hm_defines.svh ====
`ifndef HM_DEFINES_SVH
`define HM_DEFINES_SVH

// Data path widths
`define HM_DW_W       32
`define HM_TRN_W      (2 * `HM_DW_W)
`define HM_BANK_AW    10
`define HM_BANK_DEPTH (1 << `HM_BANK_AW)

// Header fields of a completion with data
`define HM_FMT_CPLD   2'b10
`define HM_TYPE_CPL   5'b01010
`define HM_BC_W       12
`define HM_LEN_W      10

// APB register map
// Window offset bit 12 selects the bank and the window spans 0x1000 to 0x2fff
`define HM_APB_AW     14
`define HM_REG_CTRL   14'h0000
`define HM_REG_STATUS 14'h0004
`define HM_REG_COUNT  14'h0008
`define HM_BANK_BASE  14'h1000

`endif

// ==== source/hm_dw_bank.sv ====
`timescale 1ns/1ps
`include "hm_defines.svh"

module hm_dw_bank
  import hm_trn_pkg::*;
(
  input  logic                   trn_clk,
  input  bank_wr_t               wr,
  input  logic [`HM_BANK_AW-1:0] rd_addr,
  output logic [`HM_DW_W-1:0]    rd_data
);

  logic [`HM_DW_W-1:0] mem [0:`HM_BANK_DEPTH-1];

  always_ff @(posedge trn_clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read data lands one cycle after the address
  always_ff @(posedge trn_clk) begin
    rd_data <= mem[rd_addr];
  end

  a_wr_addr_known: assert property (@(posedge trn_clk)
    wr.we |-> !$isunknown(wr.addr));

endmodule

// ==== source/hm_rx.sv ====
`timescale 1ns/1ps
`include "hm_defines.svh"

module hm_rx
  import hm_trn_pkg::*;
  import hm_apb_pkg::*;
(
  input  logic         trn_clk,
  input  logic         rst_n,
  input  trn_rx_beat_t beat,
  input  logic         dbg_mode,
  output bank_wr_t     wr_l,
  output bank_wr_t     wr_h,
  output rx_status_t   status
);

  function automatic logic [`HM_DW_W-1:0] bswap(input logic [`HM_DW_W-1:0] dw);
    return {dw[7:0], dw[15:8], dw[23:16], dw[31:24]};
  endfunction

  rx_state_e              state;
  logic [`HM_BANK_AW-1:0] offset_l;
  logic [`HM_BANK_AW-1:0] offset_h;
  logic                   first_dw;
  logic [`HM_BC_W-1:0]    byte_count;
  logic [`HM_LEN_W-1:0]   length;
  logic [`HM_DW_W-1:0]    tlp_count;
  logic                   read_done;

  logic                   l_we;
  logic                   h_we;
  logic [`HM_BANK_AW-1:0] l_addr;
  logic [`HM_BANK_AW-1:0] h_addr;
  logic [`HM_DW_W-1:0]    l_data;
  logic [`HM_DW_W-1:0]    h_data;

  logic                take;
  logic                sof;
  logic                eof;
  logic [`HM_DW_W-1:0] dw_l;
  logic [`HM_DW_W-1:0] dw_h;
  logic                is_cpld;
  logic                even;
  logic                lo_ok;
  logic                hi_ok;
  logic                dbg_cap;
  logic                l_we_d;
  logic                h_we_d;
  logic [`HM_DW_W-1:0] l_src;
  logic [`HM_DW_W-1:0] h_src;
  logic                last_cpl;

  assign take = !beat.rsrc_rdy_n;
  assign sof  = take && !beat.rsof_n;
  assign eof  = take && !beat.reof_n;
  assign dw_l = beat.rd[`HM_DW_W-1:0];
  assign dw_h = beat.rd[`HM_TRN_W-1:`HM_DW_W];

  assign is_cpld = (beat.rd[62:61] == `HM_FMT_CPLD) && (beat.rd[60:56] == `HM_TYPE_CPL);
  assign last_cpl = (byte_count == {length, 2'b00});

  // Sum of both offsets is the stream index of the next payload dword
  assign even = !(offset_l[0] ^ offset_h[0]);

  // Lower half always carries payload in receive; the upper half is skipped
  // on the header beat and on a half-valid end beat
  assign lo_ok = (state == rx_recv) && take;
  assign hi_ok = (state == rx_recv) && take && !first_dw && (beat.reof_n || !beat.rrem_n);

  assign dbg_cap = take && (((state == rx_idle) && !beat.rsof_n && dbg_mode) ||
                            (state == rx_dbg));

  assign l_we_d = dbg_cap || (even ? lo_ok : hi_ok);
  assign h_we_d = dbg_cap || (even ? hi_ok : lo_ok);
  assign l_src  = (dbg_cap || !even) ? dw_h : dw_l;
  assign h_src  = (dbg_cap || !even) ? dw_l : dw_h;

  always_ff @(posedge trn_clk) begin
    if (!rst_n) begin
      state     <= rx_idle;
      offset_l  <= '0;
      offset_h  <= '0;
      first_dw  <= 1'b0;
      tlp_count <= '0;
      read_done <= 1'b0;
      l_we      <= 1'b0;
      h_we      <= 1'b0;
    end else begin
      read_done <= 1'b0;
      l_we      <= l_we_d;
      h_we      <= h_we_d;
      if (l_we_d) begin
        offset_l <= offset_l + 1'b1;
      end
      if (h_we_d) begin
        offset_h <= offset_h + 1'b1;
      end
      if (eof && (state != rx_restart) && ((state != rx_idle) || sof)) begin
        tlp_count <= tlp_count + 1'b1;
      end

      case (state)
        rx_idle: begin
          if (sof) begin
            first_dw <= 1'b1;
            if (!beat.reof_n) begin
              state <= rx_idle;
            end else if (dbg_mode) begin
              state <= rx_dbg;
            end else if (is_cpld) begin
              state <= rx_recv;
            end else begin
              state <= rx_ign;
            end
          end
        end
        rx_recv: begin
          if (take) begin
            first_dw <= 1'b0;
          end
          if (eof) begin
            if (last_cpl) begin
              read_done <= 1'b1;
              state     <= rx_restart;
            end else begin
              state <= rx_idle;
            end
          end
        end
        rx_ign, rx_dbg: begin
          if (eof) begin
            state <= rx_idle;
          end
        end
        rx_restart: begin
          // Next read starts again at the bottom of both banks
          offset_l <= '0;
          offset_h <= '0;
          state    <= rx_idle;
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // Header fields and bank payloads
  always_ff @(posedge trn_clk) begin
    if ((state == rx_idle) && sof) begin
      byte_count <= beat.rd[`HM_BC_W-1:0];
      length     <= beat.rd[`HM_DW_W+`HM_LEN_W-1:`HM_DW_W];
    end
    l_addr <= offset_l;
    h_addr <= offset_h;
    l_data <= bswap(l_src);
    h_data <= bswap(h_src);
  end

  assign wr_l   = '{we: l_we, addr: l_addr, data: l_data};
  assign wr_h   = '{we: h_we, addr: h_addr, data: h_data};
  assign status = '{read_done: read_done, state: state, tlp_count: tlp_count};

  a_sof_eof_valid: assert property (@(posedge trn_clk) disable iff (!rst_n)
    beat.rsrc_rdy_n |-> (beat.rsof_n || beat.reof_n));

  a_state_legal: assert property (@(posedge trn_clk) disable iff (!rst_n)
    state inside {rx_idle, rx_recv, rx_ign, rx_dbg, rx_restart});

  // A completion stream that overruns a bank would wrap onto older data
  a_no_wrap: assert property (@(posedge trn_clk) disable iff (!rst_n)
    (state == rx_recv) |=> (offset_l >= $past(offset_l)) && (offset_h >= $past(offset_h)));

endmodule

// ==== source/hm_top.sv ====
`timescale 1ns/1ps
`include "hm_defines.svh"

module hm_top
  import hm_trn_pkg::*;
  import hm_apb_pkg::*;
(
  input  logic         trn_clk,
  input  logic         rst_n,
  input  trn_rx_beat_t trn_rx,
  input  apb_req_t     apb_req,
  output apb_rsp_t     apb_rsp
);

  bank_wr_t               wr_l;
  bank_wr_t               wr_h;
  rx_status_t             status;
  logic                   dbg_mode;
  logic [`HM_BANK_AW-1:0] bank_rd_addr;
  logic [`HM_DW_W-1:0]    rd_data_l;
  logic [`HM_DW_W-1:0]    rd_data_h;

  hm_rx u_rx (
    .trn_clk  (trn_clk),
    .rst_n    (rst_n),
    .beat     (trn_rx),
    .dbg_mode (dbg_mode),
    .wr_l     (wr_l),
    .wr_h     (wr_h),
    .status   (status)
  );

  // Even stream indexes
  hm_dw_bank u_bank_l (
    .trn_clk (trn_clk),
    .wr      (wr_l),
    .rd_addr (bank_rd_addr),
    .rd_data (rd_data_l)
  );

  // Odd stream indexes
  hm_dw_bank u_bank_h (
    .trn_clk (trn_clk),
    .wr      (wr_h),
    .rd_addr (bank_rd_addr),
    .rd_data (rd_data_h)
  );

  hm_apb_regs u_apb_regs (
    .trn_clk      (trn_clk),
    .rst_n        (rst_n),
    .req          (apb_req),
    .status       (status),
    .rd_data_l    (rd_data_l),
    .rd_data_h    (rd_data_h),
    .rsp          (apb_rsp),
    .dbg_mode     (dbg_mode),
    .bank_rd_addr (bank_rd_addr)
  );

endmodule

// ==== source/hm_trn_pkg.sv ====
`include "hm_defines.svh"

package hm_trn_pkg;

  // One beat of the 64-bit TRN receive interface
  typedef struct packed {
    logic [`HM_TRN_W-1:0] rd;
    logic                 rrem_n;
    logic                 rsof_n;
    logic                 reof_n;
    logic                 rsrc_rdy_n;
  } trn_rx_beat_t;

  // One write into a dword bank
  typedef struct packed {
    logic                   we;
    logic [`HM_BANK_AW-1:0] addr;
    logic [`HM_DW_W-1:0]    data;
  } bank_wr_t;

  // Receiver FSM states
  typedef enum logic [2:0] {
    rx_idle    = 3'd0,
    rx_recv    = 3'd1,
    rx_ign     = 3'd2,
    rx_dbg     = 3'd3,
    rx_restart = 3'd4
  } rx_state_e;

endpackage

// ==== verif/hm_tb.sv ====
`timescale 1ns/1ps
`include "hm_defines.svh"

module hm_tb
  import hm_trn_pkg::*;
  import hm_apb_pkg::*;
();

  localparam int APB_TIMEOUT = 20;
  localparam int NUM_READS   = 12;

  logic         trn_clk;
  logic         rst_n;
  trn_rx_beat_t trn_rx;
  apb_req_t     apb_req;
  apb_rsp_t     apb_rsp;

  // Payload of the current read and raw beats of the last TLP
  logic [`HM_DW_W-1:0]  payload [0:63];
  logic [`HM_TRN_W-1:0] sent [0:7];
  logic [`HM_DW_W-1:0]  exp_count;
  logic [`HM_DW_W-1:0]  rdata;
  logic                 slverr;

  hm_top u_dut (
    .trn_clk (trn_clk),
    .rst_n   (rst_n),
    .trn_rx  (trn_rx),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #5 trn_clk = ~trn_clk;

  function automatic logic [`HM_DW_W-1:0] byte_reverse(input logic [`HM_DW_W-1:0] dw);
    logic [`HM_DW_W-1:0] r;
    r = {<<8{dw}};
    return r;
  endfunction

  // Bit 12 of the window offset picks the bank and bits 11..2 the index
  function automatic logic [`HM_APB_AW-1:0] bank_addr(input logic bank, input int idx);
    logic [`HM_APB_AW-1:0] a;
    a = `HM_BANK_BASE + {1'b0, bank, idx[`HM_BANK_AW-1:0], 2'b00};
    return a;
  endfunction

  task automatic check_dword(input string name, input logic [`HM_DW_W-1:0] exp,
                             input logic [`HM_DW_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %08h, actual %08h", name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input logic [`HM_DW_W-1:0] exp,
                             input logic [`HM_DW_W-1:0] act);
    if (act !== exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_status(input string name, input rx_status_t exp, input rx_status_t act);
    if ((act.read_done !== exp.read_done) || (act.state !== exp.state)) begin
      $display("Fail %s: expected done %0b state %0d, actual done %0b state %0d",
               name, exp.read_done, exp.state, act.read_done, act.state);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected %0b, actual %0b", name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic apb_xfer(input logic write, input logic [`HM_APB_AW-1:0] addr,
                          input logic [`HM_DW_W-1:0] wdata);
    int   cycles;
    logic got;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge trn_clk);
    #1;
    apb_req.penable = 1'b1;
    cycles = 0;
    got    = 1'b0;
    while (!got) begin
      // Mid-cycle the response is settled
      @(negedge trn_clk);
      got    = apb_rsp.pready;
      rdata  = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      @(posedge trn_clk);
      #1;
      cycles++;
      if (!got && (cycles >= APB_TIMEOUT)) begin
        $display("APB transfer to %h saw no pready within %0d cycles", addr, APB_TIMEOUT);
        $display("Test FAILED");
        $fatal(1);
      end
    end
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [`HM_APB_AW-1:0] addr);
    apb_xfer(1'b0, addr, '0);
  endtask

  task automatic apb_write(input logic [`HM_APB_AW-1:0] addr, input logic [`HM_DW_W-1:0] data);
    apb_xfer(1'b1, addr, data);
  endtask

  task automatic idle_cycles(input int n);
    trn_rx = '{rd: '0, rrem_n: 1'b1, rsof_n: 1'b1, reof_n: 1'b1, rsrc_rdy_n: 1'b1};
    repeat (n) begin
      @(posedge trn_clk);
      #1;
    end
  endtask

  // Beats after the first may be preceded by a short gap
  task automatic drive_beat(input logic [`HM_TRN_W-1:0] rd, input logic sof,
                            input logic eof, input logic both);
    if (!sof && ($urandom_range(3, 0) == 0)) begin
      idle_cycles($urandom_range(2, 1));
    end
    trn_rx = '{rd: rd, rrem_n: !both, rsof_n: !sof, reof_n: !eof, rsrc_rdy_n: 1'b0};
    @(posedge trn_clk);
    #1;
  endtask

  task automatic send_completion(input int first, input int len, input int bytes_left);
    logic [`HM_DW_W-1:0] hdr0;
    logic [`HM_DW_W-1:0] hdr1;
    logic [`HM_DW_W-1:0] upper;
    int                  i;
    hdr0  = {1'b0, `HM_FMT_CPLD, `HM_TYPE_CPL, 14'h0, len[`HM_LEN_W-1:0]};
    hdr1  = {20'h0, bytes_left[`HM_BC_W-1:0]};
    drive_beat({hdr0, hdr1}, 1'b1, 1'b0, 1'b1);
    // Header dword 2 shares the second beat with payload dword 0
    upper = $urandom();
    drive_beat({upper, payload[first]}, 1'b0, len == 1, 1'b1);
    for (i = 1; i < len; i += 2) begin
      upper = (i + 1 < len) ? payload[first + i + 1] : $urandom();
      drive_beat({upper, payload[first + i]}, 1'b0, i + 2 >= len, i + 1 < len);
    end
    exp_count++;
  endtask

  // Random TLP that is never a completion with data
  task automatic send_other(input int nbeats);
    logic [`HM_TRN_W-1:0] rd;
    int                   b;
    for (b = 0; b < nbeats; b++) begin
      rd = {$urandom(), $urandom()};
      if ((b == 0) && (rd[62:56] == {`HM_FMT_CPLD, `HM_TYPE_CPL})) begin
        rd[56] = ~rd[56];
      end
      sent[b] = rd;
      drive_beat(rd, b == 0, b == nbeats - 1, $urandom_range(1, 0) == 1);
    end
    exp_count++;
  endtask

  initial begin
    int         r;
    int         c;
    int         k;
    int         n;
    int         ncpl;
    int         total;
    int         sent_dw;
    int         size;
    int         base;
    rx_status_t exp_st;
    rx_status_t act_st;
    void'($urandom(97));
    trn_clk   = 1'b0;
    rst_n     = 1'b0;
    apb_req   = '0;
    exp_count = '0;
    idle_cycles(0);
    repeat (2) @(posedge trn_clk);
    #1;
    rst_n = 1'b1;
    idle_cycles(2);

    apb_write(`HM_BANK_BASE, 32'h1234_5678);
    check_flag("bank window write", 1'b1, slverr);
    apb_read(14'h000c);
    check_flag("unmapped read", 1'b1, slverr);
    apb_read(`HM_REG_CTRL);
    check_dword("ctrl after reset", 32'h0, rdata);

    for (r = 0; r < NUM_READS; r++) begin
      n = $urandom_range(2, 0);
      repeat (n) begin
        send_other($urandom_range(4, 1));
      end
      total = $urandom_range(40, 1);
      ncpl  = $urandom_range(3, 1);
      if (ncpl > total) begin
        ncpl = total;
      end
      for (k = 0; k < total; k++) begin
        payload[k] = $urandom();
      end
      sent_dw = 0;
      for (c = 0; c < ncpl; c++) begin
        // Leave at least one dword for each remaining completion
        if (c == ncpl - 1) begin
          size = total - sent_dw;
        end else begin
          size = $urandom_range(total - sent_dw - (ncpl - 1 - c), 1);
        end
        send_completion(sent_dw, size, 4 * (total - sent_dw));
        sent_dw += size;
        idle_cycles($urandom_range(3, 2));
        apb_read(`HM_REG_STATUS);
        exp_st = '{read_done: c == ncpl - 1, state: rx_idle, tlp_count: '0};
        act_st = '{read_done: rdata[0], state: rx_state_e'(rdata[3:1]), tlp_count: '0};
        check_status("done after completion", exp_st, act_st);
      end
      apb_write(`HM_REG_STATUS, 32'h1);
      apb_read(`HM_REG_STATUS);
      exp_st = '{read_done: 1'b0, state: rx_idle, tlp_count: '0};
      act_st = '{read_done: rdata[0], state: rx_state_e'(rdata[3:1]), tlp_count: '0};
      check_status("done after clear", exp_st, act_st);
      for (k = 0; k < total; k++) begin
        apb_read(bank_addr(k[0], k / 2));
        check_dword($sformatf("stream dword %0d", k), byte_reverse(payload[k]), rdata);
      end
      apb_read(`HM_REG_COUNT);
      check_count("tlp count", exp_count, rdata);
    end

    // Raw capture of whole TLPs in debug mode
    apb_write(`HM_REG_CTRL, 32'h1);
    apb_read(`HM_REG_CTRL);
    check_dword("ctrl read-back", 32'h1, rdata);
    base = 0;
    for (r = 0; r < 3; r++) begin
      n = $urandom_range(6, 1);
      send_other(n);
      idle_cycles(2);
      for (k = 0; k < n; k++) begin
        apb_read(bank_addr(1'b0, base + k));
        check_dword("debug upper half", byte_reverse(sent[k][63:32]), rdata);
        apb_read(bank_addr(1'b1, base + k));
        check_dword("debug lower half", byte_reverse(sent[k][31:0]), rdata);
      end
      base += n;
    end
    apb_write(`HM_REG_CTRL, 32'h0);
    apb_read(`HM_REG_CTRL);
    check_dword("ctrl cleared", 32'h0, rdata);
    apb_read(`HM_REG_COUNT);
    check_count("final tlp count", exp_count, rdata);

    $display("Test OK");
    $finish;
  end

endmodule
